/* core_pkg.sv */
package core_pkg;

   localparam int xlen       = 32;
   localparam int reg_addr_w = 5;
   localparam int ram_addr_w = 10;

   localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

   // rv32i major opcodes
   localparam logic [6:0] opc_op     = 7'b0110011;
   localparam logic [6:0] opc_op_imm = 7'b0010011;
   localparam logic [6:0] opc_lui    = 7'b0110111;
   localparam logic [6:0] opc_load   = 7'b0000011;
   localparam logic [6:0] opc_store  = 7'b0100011;
   localparam logic [6:0] opc_branch = 7'b1100011;
   localparam logic [6:0] opc_jal    = 7'b1101111;

   typedef enum logic [3:0] {
      op_nop,
      op_add,
      op_sub,
      op_and,
      op_or,
      op_xor,
      op_slt,
      op_addi,
      op_lui,
      op_lw,
      op_sw,
      op_beq,
      op_bne,
      op_jal
   } op_t;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_slt,
      alu_pass_b
   } alu_t;

endpackage

/* regf.sv */
`timescale 1ns/1ps

module regf import core_pkg::*; (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic [reg_addr_w-1:0] rs1,
   input  logic [reg_addr_w-1:0] rs2,
   input  logic                  wb_we,
   input  logic [reg_addr_w-1:0] wb_rd,
   input  logic [xlen-1:0]       wb_data,
   output logic [xlen-1:0]       rs1_data,
   output logic [xlen-1:0]       rs2_data
);

   logic [xlen-1:0] regs [32];
   logic            wr_ok;

   // x0 stays zero
   assign wr_ok = wb_we && wb_rd != '0;

   always_ff @(posedge clk) begin
      if (rstn) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_ok) begin
         regs[wb_rd] <= wb_data;
      end
   end

   // write-through
   assign rs1_data = (wr_ok && wb_rd == rs1) ? wb_data : regs[rs1];
   assign rs2_data = (wr_ok && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

/* decoder.sv */
`timescale 1ns/1ps

module decoder import core_pkg::*; (
   input  logic [xlen-1:0]       fd_instr,
   output op_t                   op,
   output alu_t                  alu_op,
   output logic [reg_addr_w-1:0] rs1,
   output logic [reg_addr_w-1:0] rs2,
   output logic [reg_addr_w-1:0] rd,
   output logic [xlen-1:0]       imm,
   output logic                  use_rs1,
   output logic                  use_rs2,
   output logic                  use_imm,
   output logic                  writes_rd
);

   logic [6:0]      opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;
   logic [xlen-1:0] imm_i;
   logic [xlen-1:0] imm_s;
   logic [xlen-1:0] imm_b;
   logic [xlen-1:0] imm_u;
   logic [xlen-1:0] imm_j;

   assign opcode = fd_instr[6:0];
   assign funct3 = fd_instr[14:12];
   assign funct7 = fd_instr[31:25];
   assign rd     = fd_instr[11:7];
   assign rs1    = fd_instr[19:15];
   assign rs2    = fd_instr[24:20];

   assign imm_i = {{20{fd_instr[31]}}, fd_instr[31:20]};
   assign imm_s = {{20{fd_instr[31]}}, fd_instr[31:25], fd_instr[11:7]};
   assign imm_b = {{19{fd_instr[31]}}, fd_instr[31], fd_instr[7], fd_instr[30:25],
                   fd_instr[11:8], 1'b0};
   assign imm_u = {fd_instr[31:12], 12'h000};
   assign imm_j = {{11{fd_instr[31]}}, fd_instr[31], fd_instr[19:12], fd_instr[20],
                   fd_instr[30:21], 1'b0};

   always_comb begin
      op        = op_nop;
      alu_op    = alu_add;
      imm       = imm_i;
      use_rs1   = 1'b0;
      use_rs2   = 1'b0;
      use_imm   = 1'b0;
      writes_rd = 1'b0;
      case (opcode)
         opc_op: begin
            use_rs1   = 1'b1;
            use_rs2   = 1'b1;
            writes_rd = 1'b1;
            case ({funct7, funct3})
               {7'h00, 3'h0}: begin op = op_add; alu_op = alu_add; end
               {7'h20, 3'h0}: begin op = op_sub; alu_op = alu_sub; end
               {7'h00, 3'h7}: begin op = op_and; alu_op = alu_and; end
               {7'h00, 3'h6}: begin op = op_or;  alu_op = alu_or;  end
               {7'h00, 3'h4}: begin op = op_xor; alu_op = alu_xor; end
               {7'h00, 3'h2}: begin op = op_slt; alu_op = alu_slt; end
               default: begin
                  use_rs1   = 1'b0;
                  use_rs2   = 1'b0;
                  writes_rd = 1'b0;
               end
            endcase
         end
         opc_op_imm: begin
            if (funct3 == 3'h0) begin
               op        = op_addi;
               use_rs1   = 1'b1;
               use_imm   = 1'b1;
               writes_rd = 1'b1;
            end
         end
         opc_lui: begin
            op        = op_lui;
            alu_op    = alu_pass_b;
            imm       = imm_u;
            use_imm   = 1'b1;
            writes_rd = 1'b1;
         end
         opc_load: begin
            if (funct3 == 3'h2) begin
               op        = op_lw;
               use_rs1   = 1'b1;
               use_imm   = 1'b1;
               writes_rd = 1'b1;
            end
         end
         opc_store: begin
            if (funct3 == 3'h2) begin
               op      = op_sw;
               imm     = imm_s;
               use_rs1 = 1'b1;
               use_rs2 = 1'b1;
               use_imm = 1'b1;
            end
         end
         opc_branch: begin
            imm = imm_b;
            if (funct3 == 3'h0 || funct3 == 3'h1) begin
               op      = (funct3 == 3'h0) ? op_beq : op_bne;
               use_rs1 = 1'b1;
               use_rs2 = 1'b1;
            end
         end
         opc_jal: begin
            op        = op_jal;
            imm       = imm_j;
            writes_rd = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

/* pipe_ctrl.sv */
`timescale 1ns/1ps

module pipe_ctrl import core_pkg::*; (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic [xlen-1:0]       rom_data,
   input  logic                  use_rs1,
   input  logic                  use_rs2,
   input  logic [reg_addr_w-1:0] rs1,
   input  logic [reg_addr_w-1:0] rs2,
   input  logic                  ex_load,
   input  logic [reg_addr_w-1:0] ex_rd,
   input  logic                  redirect,
   input  logic [xlen-1:0]       redirect_pc,
   output logic [xlen-1:0]       rom_addr,
   output logic [xlen-1:0]       fd_instr,
   output logic [xlen-1:0]       fd_pc,
   output logic                  fd_valid,
   output logic                  bubble
);

   logic [xlen-1:0] pc;
   logic            rs1_hit;
   logic            rs2_hit;
   logic            stall;

   assign rom_addr = pc;

   ////////////////////////////////////////
   // load-use hazard
   ////////////////////////////////////////

   // loaded value is not ready until it reaches write-back
   assign rs1_hit = use_rs1 && rs1 == ex_rd;
   assign rs2_hit = use_rs2 && rs2 == ex_rd;
   assign stall   = fd_valid && ex_load && ex_rd != '0 && (rs1_hit || rs2_hit);

   // redirect wins over stall
   assign bubble = redirect || stall;

   ////////////////////////////////////////
   // pc and fetch/decode register
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         pc       <= reset_pc;
         fd_valid <= 1'b0;
      end else if (redirect) begin
         pc       <= redirect_pc;
         fd_valid <= 1'b0;
      end else if (!stall) begin
         pc       <= pc + 32'd4;
         fd_valid <= 1'b1;
      end
   end

   // held during a stall, dropped by fd_valid on redirect
   always_ff @(posedge clk) begin
      if (!stall) begin
         fd_instr <= rom_data;
         fd_pc    <= pc;
      end
   end

endmodule

/* execute.sv */
`timescale 1ns/1ps

module execute import core_pkg::*; (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  bubble,
   input  logic                  fd_valid,
   input  logic [xlen-1:0]       fd_pc,
   input  op_t                   op,
   input  alu_t                  alu_op,
   input  logic [reg_addr_w-1:0] rs1,
   input  logic [reg_addr_w-1:0] rs2,
   input  logic [reg_addr_w-1:0] rd,
   input  logic [xlen-1:0]       imm,
   input  logic                  use_rs1,
   input  logic                  use_rs2,
   input  logic                  use_imm,
   input  logic                  writes_rd,
   input  logic [xlen-1:0]       rs1_data,
   input  logic [xlen-1:0]       rs2_data,
   input  logic [xlen-1:0]       mem_result,
   input  logic [reg_addr_w-1:0] mem_rd,
   input  logic                  mem_writes,
   input  logic                  wb_we,
   input  logic [reg_addr_w-1:0] wb_rd,
   input  logic [xlen-1:0]       wb_data,
   output logic                  ex_valid,
   output logic                  ex_load,
   output logic                  ex_store,
   output logic                  ex_writes,
   output logic [reg_addr_w-1:0] ex_rd,
   output logic [xlen-1:0]       ex_result,
   output logic [xlen-1:0]       ex_store_data,
   output logic                  redirect,
   output logic [xlen-1:0]       redirect_pc
);

   logic                  d_valid;
   op_t                   d_op;
   alu_t                  d_alu;
   logic [reg_addr_w-1:0] d_rs1;
   logic [reg_addr_w-1:0] d_rs2;
   logic [reg_addr_w-1:0] d_rd;
   logic [xlen-1:0]       d_imm;
   logic [xlen-1:0]       d_pc;
   logic [xlen-1:0]       d_rs1_data;
   logic [xlen-1:0]       d_rs2_data;
   logic                  d_use_rs1;
   logic                  d_use_rs2;
   logic                  d_use_imm;
   logic                  d_writes;
   logic                  a_hit_mem;
   logic                  a_hit_wb;
   logic                  b_hit_mem;
   logic                  b_hit_wb;
   logic [xlen-1:0]       rs1_fwd;
   logic [xlen-1:0]       rs2_fwd;
   logic [xlen-1:0]       alu_b;
   logic [xlen-1:0]       alu_out;
   logic                  taken;

   ////////////////////////////////////////
   // decode/execute register
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         d_valid <= 1'b0;
      end else begin
         d_valid <= fd_valid && !bubble;
      end
   end

   always_ff @(posedge clk) begin
      d_op       <= op;
      d_alu      <= alu_op;
      d_rs1      <= rs1;
      d_rs2      <= rs2;
      d_rd       <= rd;
      d_imm      <= imm;
      d_pc       <= fd_pc;
      d_rs1_data <= rs1_data;
      d_rs2_data <= rs2_data;
      d_use_rs1  <= use_rs1;
      d_use_rs2  <= use_rs2;
      d_use_imm  <= use_imm;
      d_writes   <= writes_rd;
   end

   ////////////////////////////////////////
   // forwarding, newest writer first
   ////////////////////////////////////////

   assign a_hit_mem = d_use_rs1 && d_rs1 != '0 && mem_writes && mem_rd == d_rs1;
   assign a_hit_wb  = d_use_rs1 && d_rs1 != '0 && wb_we && wb_rd == d_rs1;
   assign b_hit_mem = d_use_rs2 && d_rs2 != '0 && mem_writes && mem_rd == d_rs2;
   assign b_hit_wb  = d_use_rs2 && d_rs2 != '0 && wb_we && wb_rd == d_rs2;

   assign rs1_fwd = a_hit_mem ? mem_result : a_hit_wb ? wb_data : d_rs1_data;
   assign rs2_fwd = b_hit_mem ? mem_result : b_hit_wb ? wb_data : d_rs2_data;
   assign alu_b   = d_use_imm ? d_imm : rs2_fwd;

   always_comb begin
      case (d_alu)
         alu_add:    alu_out = rs1_fwd + alu_b;
         alu_sub:    alu_out = rs1_fwd - alu_b;
         alu_and:    alu_out = rs1_fwd & alu_b;
         alu_or:     alu_out = rs1_fwd | alu_b;
         alu_xor:    alu_out = rs1_fwd ^ alu_b;
         alu_slt:    alu_out = {{(xlen-1){1'b0}}, $signed(rs1_fwd) < $signed(alu_b)};
         alu_pass_b: alu_out = alu_b;
         default:    alu_out = '0;
      endcase
   end

   // branch and jump resolution
   assign taken = (d_op == op_beq && rs1_fwd == rs2_fwd) ||
                  (d_op == op_bne && rs1_fwd != rs2_fwd);
   assign redirect    = d_valid && (d_op == op_jal || taken);
   assign redirect_pc = d_pc + d_imm;

   assign ex_valid      = d_valid;
   assign ex_load       = d_valid && d_op == op_lw;
   assign ex_store      = d_valid && d_op == op_sw;
   assign ex_writes     = d_valid && d_writes;
   assign ex_rd         = d_rd;
   assign ex_result     = (d_op == op_jal) ? d_pc + 32'd4 : alu_out;
   assign ex_store_data = rs2_fwd;

endmodule

/* mem_stage.sv */
`timescale 1ns/1ps

module mem_stage import core_pkg::*; (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  ex_valid,
   input  logic                  ex_load,
   input  logic                  ex_store,
   input  logic                  ex_writes,
   input  logic [reg_addr_w-1:0] ex_rd,
   input  logic [xlen-1:0]       ex_result,
   input  logic [xlen-1:0]       ex_store_data,
   input  logic [xlen-1:0]       ram_rdata,
   output logic [ram_addr_w-1:0] ram_addr,
   output logic [xlen-1:0]       ram_wdata,
   output logic                  ram_we,
   output logic [xlen-1:0]       mem_result,
   output logic [reg_addr_w-1:0] mem_rd,
   output logic                  mem_writes,
   output logic                  wb_we,
   output logic [reg_addr_w-1:0] wb_rd,
   output logic [xlen-1:0]       wb_data
);

   logic                  m_valid;
   logic                  m_load;
   logic                  m_store;
   logic                  m_writes;
   logic [reg_addr_w-1:0] m_rd;
   logic [xlen-1:0]       m_result;
   logic [xlen-1:0]       m_store_data;

   ////////////////////////////////////////
   // execute/memory register
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         m_valid <= 1'b0;
      end else begin
         m_valid <= ex_valid;
      end
   end

   always_ff @(posedge clk) begin
      m_load       <= ex_load;
      m_store      <= ex_store;
      m_writes     <= ex_writes;
      m_rd         <= ex_rd;
      m_result     <= ex_result;
      m_store_data <= ex_store_data;
   end

   // word addressed ram
   assign ram_addr  = m_result[ram_addr_w+1:2];
   assign ram_wdata = m_store_data;
   assign ram_we    = m_valid && m_store;

   // load data not ready here, the load-use stall covers it
   assign mem_result = m_result;
   assign mem_rd     = m_rd;
   assign mem_writes = m_valid && m_writes && !m_load;

   ////////////////////////////////////////
   // memory/write-back register
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         wb_we <= 1'b0;
      end else begin
         wb_we <= m_valid && m_writes;
      end
   end

   always_ff @(posedge clk) begin
      wb_rd   <= m_rd;
      wb_data <= m_load ? ram_rdata : m_result;
   end

endmodule

/* core.sv */
`timescale 1ns/1ps

module core import core_pkg::*; (
   input  logic                  clk,
   input  logic                  rstn,
   output logic [xlen-1:0]       rom_addr,
   input  logic [xlen-1:0]       rom_data,
   output logic [ram_addr_w-1:0] ram_addr,
   output logic [xlen-1:0]       ram_wdata,
   output logic                  ram_we,
   input  logic [xlen-1:0]       ram_rdata
);

   // fetch / decode
   logic [xlen-1:0]       fd_instr;
   logic [xlen-1:0]       fd_pc;
   logic                  fd_valid;
   logic                  bubble;
   op_t                   op;
   alu_t                  alu_op;
   logic [reg_addr_w-1:0] rs1;
   logic [reg_addr_w-1:0] rs2;
   logic [reg_addr_w-1:0] rd;
   logic [xlen-1:0]       imm;
   logic                  use_rs1;
   logic                  use_rs2;
   logic                  use_imm;
   logic                  writes_rd;
   logic [xlen-1:0]       rs1_data;
   logic [xlen-1:0]       rs2_data;

   // execute
   logic                  ex_valid;
   logic                  ex_load;
   logic                  ex_store;
   logic                  ex_writes;
   logic [reg_addr_w-1:0] ex_rd;
   logic [xlen-1:0]       ex_result;
   logic [xlen-1:0]       ex_store_data;
   logic                  redirect;
   logic [xlen-1:0]       redirect_pc;

   // memory / write-back
   logic [xlen-1:0]       mem_result;
   logic [reg_addr_w-1:0] mem_rd;
   logic                  mem_writes;
   logic                  wb_we;
   logic [reg_addr_w-1:0] wb_rd;
   logic [xlen-1:0]       wb_data;

   pipe_ctrl i_pipe_ctrl (
      .clk, .rstn, .rom_data, .use_rs1, .use_rs2, .rs1, .rs2,
      .ex_load, .ex_rd, .redirect, .redirect_pc,
      .rom_addr, .fd_instr, .fd_pc, .fd_valid, .bubble
   );

   decoder i_decoder (
      .fd_instr, .op, .alu_op, .rs1, .rs2, .rd, .imm,
      .use_rs1, .use_rs2, .use_imm, .writes_rd
   );

   regf i_regf (
      .clk, .rstn, .rs1, .rs2, .wb_we, .wb_rd, .wb_data, .rs1_data, .rs2_data
   );

   execute i_execute (
      .clk, .rstn, .bubble, .fd_valid, .fd_pc,
      .op, .alu_op, .rs1, .rs2, .rd, .imm, .use_rs1, .use_rs2, .use_imm, .writes_rd,
      .rs1_data, .rs2_data, .mem_result, .mem_rd, .mem_writes, .wb_we, .wb_rd, .wb_data,
      .ex_valid, .ex_load, .ex_store, .ex_writes, .ex_rd, .ex_result, .ex_store_data,
      .redirect, .redirect_pc
   );

   mem_stage i_mem_stage (
      .clk, .rstn, .ex_valid, .ex_load, .ex_store, .ex_writes, .ex_rd, .ex_result,
      .ex_store_data, .ram_rdata, .ram_addr, .ram_wdata, .ram_we,
      .mem_result, .mem_rd, .mem_writes, .wb_we, .wb_rd, .wb_data
   );

endmodule

/* tb_core.sv */
`timescale 1ns/1ps

module tb_core import core_pkg::*; ();

   logic                  clk;
   logic                  rstn;
   logic [xlen-1:0]       rom_addr;
   logic [xlen-1:0]       rom_data;
   logic [ram_addr_w-1:0] ram_addr;
   logic [xlen-1:0]       ram_wdata;
   logic                  ram_we;
   logic [xlen-1:0]       ram_rdata;

   logic [31:0] rom [256];
   logic [31:0] ram [1024];
   logic [31:0] mdl_mem [1024];
   string       sect_of [256];
   int          n_prog;
   string       cur_test;
   logic [31:0] seed;
   logic [31:0] marker;
   int          errors;
   int          checked;
   int          n_exp;
   bit          prog_ready;
   logic [9:0]  exp_addr [$];
   logic [31:0] exp_data [$];
   string       exp_name [$];
   string       chk_name;
   logic [9:0]  chk_addr;
   logic [31:0] chk_data;

   core i_core (
      .clk, .rstn, .rom_addr, .rom_data, .ram_addr, .ram_wdata, .ram_we, .ram_rdata
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // combinational rom and ram reads
   assign rom_data  = rom[rom_addr[9:2]];
   assign ram_rdata = ram[ram_addr];

   always @(posedge clk) begin
      if (ram_we) begin
         ram[ram_addr] <= ram_wdata;
      end
   end

   ////////////////////////////////////////
   // program assembly
   ////////////////////////////////////////

   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, 7'h33};
   endfunction

   function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
      return {imm, rs1, 3'h0 | {1'b0, opc == 7'h03, 1'b0}, rd, opc};
   endfunction

   function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'h2, imm[4:0], 7'h23};
   endfunction

   function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
   endfunction

   function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
      return {imm, rd, 7'h37};
   endfunction

   function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
   endfunction

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // every bit of the word address shows up in the data
   function automatic logic [31:0] fill_word(input logic [9:0] a);
      return {a, 2'b00, ~a, 2'b11, a[7:0]};
   endfunction

   task automatic emit(input logic [31:0] w);
      rom[n_prog[7:0]]     = w;
      sect_of[n_prog[7:0]] = cur_test;
      n_prog++;
   endtask

   task automatic build_program();
      logic [31:0] rnd;
      marker = {20'hdead0, 12'h000};
      cur_test = "alu";
      emit(i_type(7'h13, 10, 0, 12'h200));
      emit(u_type(20, marker[31:12]));
      rnd = lcg_next();
      emit(i_type(7'h13, 1, 0, rnd[27:16]));
      emit(s_type(1, 10, 12'd0));
      rnd = lcg_next();
      emit(i_type(7'h13, 2, 1, rnd[27:16]));
      emit(s_type(2, 10, 12'd4));
      emit(r_type(7'h00, 3'h0, 3, 1, 2));
      emit(s_type(3, 10, 12'd8));
      emit(r_type(7'h20, 3'h0, 4, 3, 2));
      emit(s_type(4, 10, 12'd12));
      emit(r_type(7'h00, 3'h7, 5, 4, 3));
      emit(s_type(5, 10, 12'd16));
      emit(r_type(7'h00, 3'h6, 6, 5, 2));
      emit(s_type(6, 10, 12'd20));
      emit(r_type(7'h00, 3'h4, 7, 6, 1));
      emit(s_type(7, 10, 12'd24));
      emit(r_type(7'h00, 3'h2, 8, 7, 2));
      emit(s_type(8, 10, 12'd28));
      emit(u_type(9, 20'habcde));
      emit(s_type(9, 10, 12'd32));
      emit(r_type(7'h00, 3'h4, 9, 9, 7));
      emit(s_type(9, 10, 12'd36));
      cur_test = "load_use";
      emit(i_type(7'h03, 11, 0, 12'd64));
      emit(r_type(7'h00, 3'h0, 12, 11, 1));
      emit(s_type(12, 10, 12'd40));
      emit(i_type(7'h03, 13, 0, 12'd68));
      emit(s_type(13, 10, 12'd44));
      cur_test = "redirect";
      emit(i_type(7'h13, 14, 0, 12'd5));
      emit(i_type(7'h13, 15, 0, 12'd5));
      emit(b_type(3'h0, 15, 14, 13'd12));
      emit(s_type(20, 10, 12'd48));
      emit(s_type(20, 10, 12'd52));
      // not taken so the next two stores are real
      emit(b_type(3'h1, 14, 15, 13'd12));
      emit(s_type(14, 10, 12'd56));
      emit(s_type(15, 10, 12'd60));
      emit(i_type(7'h13, 16, 0, 12'h033));
      emit(j_type(17, 21'd12));
      emit(s_type(20, 10, 12'd64));
      emit(s_type(20, 10, 12'd68));
      emit(s_type(17, 10, 12'd72));
      emit(s_type(16, 10, 12'd76));
      cur_test = "x0";
      emit(i_type(7'h13, 0, 0, 12'd123));
      emit(s_type(0, 10, 12'd80));
      cur_test = "end";
      emit(j_type(0, 21'd0));
   endtask

   ////////////////////////////////////////
   // in-order reference model
   ////////////////////////////////////////

   task automatic run_model();
      logic [31:0] x [32];
      logic [31:0] pc;
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] nxt;
      logic [31:0] ea;
      logic [4:0]  rd;
      int          steps;
      for (int i = 0; i < 32; i++) begin
         x[i[4:0]] = '0;
      end
      pc    = reset_pc;
      steps = 0;
      ins   = rom[pc[9:2]];
      while (ins != j_type(0, 21'd0) && steps < 1000) begin
         rd  = ins[11:7];
         a   = x[ins[19:15]];
         b   = x[ins[24:20]];
         nxt = pc + 32'd4;
         case (ins[6:0])
            7'h33: begin
               case ({ins[31:25], ins[14:12]})
                  10'h000: x[rd] = a + b;
                  10'h100: x[rd] = a - b;
                  10'h007: x[rd] = a & b;
                  10'h006: x[rd] = a | b;
                  10'h004: x[rd] = a ^ b;
                  10'h002: x[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default: ;
               endcase
            end
            7'h13: x[rd] = a + {{20{ins[31]}}, ins[31:20]};
            7'h37: x[rd] = {ins[31:12], 12'h000};
            7'h03: begin
               ea    = a + {{20{ins[31]}}, ins[31:20]};
               x[rd] = mdl_mem[ea[11:2]];
            end
            7'h23: begin
               ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
               mdl_mem[ea[11:2]] = b;
               exp_addr.push_back(ea[11:2]);
               exp_data.push_back(b);
               exp_name.push_back(sect_of[pc[9:2]]);
            end
            7'h63: begin
               if ((ins[14:12] == 3'h0 && a == b) || (ins[14:12] == 3'h1 && a != b)) begin
                  nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
               end
            end
            7'h6f: begin
               x[rd] = pc + 32'd4;
               nxt   = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: ;
         endcase
         x[0]  = '0;
         pc    = nxt;
         steps++;
         ins   = rom[pc[9:2]];
      end
   endtask

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   assert property (@(posedge clk) rstn |-> !ram_we)
   else begin
      errors++;
      $display("ram write enable was high while reset was asserted");
   end

   always @(negedge clk) begin
      if (ram_we) begin
         assert (ram_wdata != marker)
         else begin
            errors++;
            $display("a store from a flushed slot reached word %0d", ram_addr);
         end
         if (exp_data.size() == 0) begin
            errors++;
            $display("store to word %0d after the last expected store", ram_addr);
         end else begin
            chk_name = exp_name.pop_front();
            chk_addr = exp_addr.pop_front();
            chk_data = exp_data.pop_front();
            assert (ram_addr == chk_addr)
            else begin
               errors++;
               $display("** Error [%s] store address: expected %0d, actual %0d",
                        chk_name, chk_addr, ram_addr);
            end
            assert (ram_wdata == chk_data)
            else begin
               errors++;
               $display("** Error [%s] store data: expected %h, actual %h",
                        chk_name, chk_data, ram_wdata);
            end
            checked++;
         end
      end
   end

   // run length follows the program size
   initial begin
      wait (prog_ready);
      repeat (16 + n_prog * 4 + 64) @(posedge clk);
      $display("timeout: %0d of %0d stores seen before the cycle limit", checked, n_exp);
      $display("Something failed");
      $finish;
   end

   initial begin
      rstn       = 1'b1;
      seed       = 32'h4577064c;
      errors     = 0;
      checked    = 0;
      n_prog     = 0;
      prog_ready = 1'b0;
      for (int i = 0; i < 256; i++) begin
         rom[i[7:0]] = '0;
      end
      for (int i = 0; i < 1024; i++) begin
         ram[i[9:0]]     <= fill_word(i[9:0]);
         mdl_mem[i[9:0]] = fill_word(i[9:0]);
      end
      build_program();
      run_model();
      n_exp      = exp_data.size();
      prog_ready = 1'b1;

      repeat (16) @(negedge clk);
      rstn = 1'b0;
      assert (rom_addr == reset_pc)
      else begin
         errors++;
         $display("** Error [reset] first fetch address: expected %h, actual %h",
                  reset_pc, rom_addr);
      end
      @(negedge clk);
      assert (!ram_we)
      else begin
         errors++;
         $display("ram write enable was high in the first cycle after reset");
      end

      while (exp_data.size() != 0) @(negedge clk);
      repeat (20) @(negedge clk);
      $display("errors: %0d, stores checked: %0d of %0d", errors, checked, n_exp);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

/* sim.f */
core_pkg.sv
regf.sv
decoder.sv
pipe_ctrl.sv
execute.sv
mem_stage.sv
core.sv
tb_core.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, then look for the pass line in the output
verilator --binary --assert --top-module tb_core -f sim.f -o tb_core_sim &&
./obj_dir/tb_core_sim | tee /dev/stderr | grep -x "Everything OK" > /dev/null &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
